// File: files.f
+incdir+tb
hw/rtc_init_pkg.sv
hw/rtc_init_program.sv
hw/axi_write_master.sv
hw/rtc_init_sequencer.sv
hw/rtc_init_top.sv
tb/tb_rtc_init.sv

// File: hw/axi_write_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_master
    import rtc_init_pkg::*;
(
    input  wire                      s_axi_aclk,
    input  wire                      s_axi_reset,

    // request side
    input  wire                      write_start,
    input  wire  [axi_addr_w-1:0]    wr_addr,
    input  wire  [axi_data_w-1:0]    wr_data,
    output logic                     write_done,

    // write address channel
    output logic [axi_addr_w-1:0]    s_axi_awaddr,
    output logic                     s_axi_awvalid,
    input  wire                      s_axi_awready,

    // write data channel
    output logic [axi_data_w-1:0]    s_axi_wdata,
    output logic                     s_axi_wvalid,
    input  wire                      s_axi_wready,

    // write response channel
    input  wire                      s_axi_bvalid,
    output logic                     s_axi_bready
);

    // sticky per-channel completion
    logic aw_done;
    logic w_done;
    logic b_done;

    // transfers in this cycle
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic all_done;

    assign aw_hs = s_axi_awvalid & s_axi_awready;
    assign w_hs  = s_axi_wvalid & s_axi_wready;
    assign b_hs  = s_axi_bready & s_axi_bvalid;

    // last outstanding channel completes now or already has
    assign all_done = (aw_done | aw_hs) & (w_done | w_hs) & (b_done | b_hs);

    // ------------------------------------------------------------------------
    // payload, captured once per write and held until the transfer
    // ------------------------------------------------------------------------

    always_ff @(posedge s_axi_aclk) begin
        if (write_start) begin
            s_axi_awaddr <= wr_addr;
            s_axi_wdata  <= wr_data;
        end
    end

    // ------------------------------------------------------------------------
    // channel handshakes
    // ------------------------------------------------------------------------

    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_reset) begin
            s_axi_awvalid <= 1'b0;
            s_axi_wvalid  <= 1'b0;
            s_axi_bready  <= 1'b0;
            aw_done       <= 1'b0;
            w_done        <= 1'b0;
            b_done        <= 1'b0;
            write_done    <= 1'b0;
        end else begin
            write_done <= 1'b0;

            // all three channels open together
            if (write_start) begin
                s_axi_awvalid <= 1'b1;
                s_axi_wvalid  <= 1'b1;
                s_axi_bready  <= 1'b1;
            end

            // each channel drops out on its own transfer
            if (aw_hs) begin
                s_axi_awvalid <= 1'b0;
            end
            if (w_hs) begin
                s_axi_wvalid <= 1'b0;
            end
            if (b_hs) begin
                s_axi_bready <= 1'b0;
            end

            if (all_done) begin
                // whole write finished, rearm for the next one
                write_done <= 1'b1;
                aw_done    <= 1'b0;
                w_done     <= 1'b0;
                b_done     <= 1'b0;
            end else begin
                aw_done <= aw_done | aw_hs;
                w_done  <= w_done | w_hs;
                b_done  <= b_done | b_hs;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rtc_init_pkg.sv
`default_nettype none

package rtc_init_pkg;

    // ------------------------------------------------------------------------
    // bus geometry
    // ------------------------------------------------------------------------

    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;

    // ------------------------------------------------------------------------
    // rtc register map, only the registers touched by the init program
    // ------------------------------------------------------------------------

    // control / command register
    localparam logic [axi_addr_w-1:0] rtc_ctrl_addr     = 32'h0000_0000;
    // clock period, integer ns in the high word
    localparam logic [axi_addr_w-1:0] rtc_period_h_addr = 32'h0000_0020;
    // fractional ns in the low word
    localparam logic [axi_addr_w-1:0] rtc_period_l_addr = 32'h0000_0024;

    // 16 ns reference clock
    localparam logic [axi_data_w-1:0] rtc_period_h_val  = 32'h0000_0010;
    // no fractional part
    localparam logic [axi_data_w-1:0] rtc_period_l_val  = 32'h0000_0000;

    // command codes written to the control register
    typedef enum logic [axi_data_w-1:0] {
        clear      = 32'h0000_0000,
        set_period = 32'h0000_0004,
        set_reset  = 32'h0000_0010
    } rtc_ctrl_op_e;

    // ------------------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------------------

    // idle cycles after reset release before the first write
    localparam int powerup_delay = 200;
    // rtc needs time to come out of its own reset
    localparam int settle_cycles = 16;
    // writes in the init program
    localparam int init_steps    = 6;

    // counter widths, sized to hold the terminal values
    localparam int powerup_cnt_w = $clog2(powerup_delay + 1);
    localparam int settle_cnt_w  = $clog2(settle_cycles + 1);

    // program step index
    typedef logic [2:0] step_idx_t;

    // sequencer states
    typedef enum logic [2:0] {
        seq_powerup,
        seq_issue,
        seq_busy,
        seq_settle,
        seq_finish
    } seq_state_e;

endpackage

`default_nettype wire

// File: hw/rtc_init_program.sv
`timescale 1ns/10ps
`default_nettype none

module rtc_init_program
    import rtc_init_pkg::*;
(
    input  wire step_idx_t               step,
    output logic      [axi_addr_w-1:0]   wr_addr,
    output logic      [axi_data_w-1:0]   wr_data,
    output logic                         step_settle,
    output logic                         step_last
);

    // ------------------------------------------------------------------------
    // rtc bring-up program
    // ------------------------------------------------------------------------

    always_comb begin
        // most steps write control with no settle
        wr_addr     = rtc_ctrl_addr;
        wr_data     = clear;
        step_settle = 1'b0;
        case (step)
            // start from a known control value
            3'd0: begin
                wr_addr = rtc_ctrl_addr;
                wr_data = clear;
            end
            // reset command, rtc needs a few cycles afterwards
            3'd1: begin
                wr_addr     = rtc_ctrl_addr;
                wr_data     = set_reset;
                step_settle = 1'b1;
            end
            // period staged in the two holding words
            3'd2: begin
                wr_addr = rtc_period_h_addr;
                wr_data = rtc_period_h_val;
            end
            3'd3: begin
                wr_addr = rtc_period_l_addr;
                wr_data = rtc_period_l_val;
            end
            // command edges are seen on a change, so clear first
            3'd4: begin
                wr_addr = rtc_ctrl_addr;
                wr_data = clear;
            end
            // commit the staged period
            3'd5: begin
                wr_addr = rtc_ctrl_addr;
                wr_data = set_period;
            end
            default: begin
                wr_addr = rtc_ctrl_addr;
                wr_data = clear;
            end
        endcase
    end

    // final write of the table
    assign step_last = (step == step_idx_t'(init_steps - 1));

endmodule

`default_nettype wire

// File: hw/rtc_init_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module rtc_init_sequencer
    import rtc_init_pkg::*;
(
    input  wire              s_axi_aclk,
    input  wire              s_axi_reset,

    // write master handshake
    output logic             write_start,
    input  wire              write_done,

    // program lookup
    output step_idx_t        step,
    input  wire              step_settle,
    input  wire              step_last,

    output logic             rtc_init_done
);

    seq_state_e                state;
    logic [powerup_cnt_w-1:0]  powerup_cnt;
    logic [settle_cnt_w-1:0]   settle_cnt;

    // terminal counts
    logic powerup_end;
    logic settle_end;

    assign powerup_end = (powerup_cnt == powerup_cnt_w'(powerup_delay - 1));
    assign settle_end  = (settle_cnt == settle_cnt_w'(settle_cycles - 1));

    // ------------------------------------------------------------------------
    // wait counters
    // ------------------------------------------------------------------------

    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_reset) begin
            powerup_cnt <= '0;
        end else if (state == seq_powerup && !powerup_end) begin
            powerup_cnt <= powerup_cnt + 1'b1;
        end
    end

    // restarts on every entry to settle
    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_reset) begin
            settle_cnt <= '0;
        end else if (state == seq_settle) begin
            settle_cnt <= settle_cnt + 1'b1;
        end else begin
            settle_cnt <= '0;
        end
    end

    // ------------------------------------------------------------------------
    // control FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_reset) begin
            state         <= seq_powerup;
            step          <= '0;
            write_start   <= 1'b0;
            rtc_init_done <= 1'b0;
        end else begin
            // strobe only
            write_start <= 1'b0;

            case (state)
                // let the rtc and the bus come up
                seq_powerup: begin
                    if (powerup_end) begin
                        state <= seq_issue;
                    end
                end

                // kick one write, step stays put until it completes
                seq_issue: begin
                    write_start <= 1'b1;
                    state       <= seq_busy;
                end

                seq_busy: begin
                    if (write_done) begin
                        if (step_last) begin
                            // program complete
                            rtc_init_done <= 1'b1;
                            state         <= seq_finish;
                        end else if (step_settle) begin
                            state <= seq_settle;
                        end else begin
                            step  <= step + 1'b1;
                            state <= seq_issue;
                        end
                    end
                end

                // quiet gap after the rtc reset command
                seq_settle: begin
                    if (settle_end) begin
                        step  <= step + 1'b1;
                        state <= seq_issue;
                    end
                end

                // parked, no more bus traffic
                seq_finish: begin
                    state <= seq_finish;
                end

                default: begin
                    state <= seq_powerup;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/rtc_init_top.sv
`timescale 1ns/10ps
`default_nettype none

module rtc_init_top
    import rtc_init_pkg::*;
(
    input  wire                      s_axi_aclk,
    input  wire                      s_axi_reset,

    output logic [axi_addr_w-1:0]    s_axi_awaddr,
    output logic                     s_axi_awvalid,
    input  wire                      s_axi_awready,

    output logic [axi_data_w-1:0]    s_axi_wdata,
    output logic                     s_axi_wvalid,
    input  wire                      s_axi_wready,

    input  wire                      s_axi_bvalid,
    output logic                     s_axi_bready,

    output logic                     rtc_init_done
);

    // sequencer to master
    logic                    write_start;
    logic                    write_done;

    // sequencer to program
    step_idx_t               step;
    logic [axi_addr_w-1:0]   wr_addr;
    logic [axi_data_w-1:0]   wr_data;
    logic                    step_settle;
    logic                    step_last;

    rtc_init_sequencer rtc_init_sequencer_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_reset   (s_axi_reset),
        .write_start   (write_start),
        .write_done    (write_done),
        .step          (step),
        .step_settle   (step_settle),
        .step_last     (step_last),
        .rtc_init_done (rtc_init_done)
    );

    rtc_init_program rtc_init_program_i (
        .step        (step),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .step_settle (step_settle),
        .step_last   (step_last)
    );

    axi_write_master axi_write_master_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_reset   (s_axi_reset),
        .write_start   (write_start),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .write_done    (write_done),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rtc init testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_rtc_init \
    -f files.f -o sim_tb_rtc_init
./obj_dir/sim_tb_rtc_init | tee sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi

// File: tb/rtc_init_expected.svh
`ifndef rtc_init_expected_svh
`define rtc_init_expected_svh

// ------------------------------------------------------------------------
// timing of the init run
// ------------------------------------------------------------------------

localparam int reset_cycles     = 10;
localparam int powerup_delay    = 200;
localparam int settle_cycles    = 16;
localparam int init_steps       = 6;
// the set_reset write, followed by the settle gap
localparam int settle_write     = 1;
// one write with the slave stalling each ready and bvalid up to 7 cycles
localparam int write_max_cycles = 30;
// last response to rtc_init_done
localparam int done_wait_cycles = 8;
// bus must stay idle this long once done
localparam int quiet_cycles     = 50;

localparam int run_budget = reset_cycles + powerup_delay + settle_cycles
                          + init_steps * write_max_cycles + quiet_cycles;
// twice the budget, rounded up to a hundred
localparam int timeout_cycles = ((2 * run_budget + 99) / 100) * 100;

// ------------------------------------------------------------------------
// expected writes in program order
// ------------------------------------------------------------------------

// control 0x00, period high 0x20, period low 0x24
localparam logic [31:0] exp_addr [init_steps] = '{
    32'h0000_0000, 32'h0000_0000, 32'h0000_0020,
    32'h0000_0024, 32'h0000_0000, 32'h0000_0000
};

// clear, reset command 0x10, 16 ns, no fraction, clear, set period 0x04
localparam logic [31:0] exp_data [init_steps] = '{
    32'h0000_0000, 32'h0000_0010, 32'h0000_0010,
    32'h0000_0000, 32'h0000_0000, 32'h0000_0004
};

function automatic string write_name(input int idx);
    case (idx)
        0:       return "ctrl_clear";
        1:       return "ctrl_set_reset";
        2:       return "period_high";
        3:       return "period_low";
        4:       return "ctrl_clear_again";
        default: return "ctrl_set_period";
    endcase
endfunction

`endif

// File: tb/tb_rtc_init.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rtc_init;

    `include "rtc_init_expected.svh"

    // inputs idle and reset held from time zero
    logic        s_axi_aclk    = 1'b0;
    logic        s_axi_reset   = 1'b1;
    logic        s_axi_awready = 1'b0;
    logic        s_axi_wready  = 1'b0;
    logic        s_axi_bvalid  = 1'b0;
    logic [31:0] s_axi_awaddr;
    logic [31:0] s_axi_wdata;
    logic        s_axi_awvalid;
    logic        s_axi_wvalid;
    logic        s_axi_bready;
    logic        rtc_init_done;

    // transfers at this edge
    logic aw_xfer;
    logic w_xfer;
    logic b_xfer;

    // slave model
    int   aw_wait  = 0;
    int   w_wait   = 0;
    int   b_wait   = 0;
    logic aw_armed = 1'b0;
    logic w_armed  = 1'b0;
    logic b_armed  = 1'b0;
    logic aw_got   = 1'b0;
    logic w_got    = 1'b0;

    // monitor
    int          cyc    = 0;
    int          aw_cnt = 0;
    int          w_cnt  = 0;
    int          b_cnt  = 0;
    logic [31:0] aw_addr_seen [init_steps];
    logic [31:0] w_data_seen  [init_steps];
    int          aw_rise_cyc  [init_steps];
    int          b_cyc        [init_steps];
    logic        awvalid_q = 1'b0;
    logic        wvalid_q  = 1'b0;
    logic        bready_q  = 1'b0;
    logic        aw_xfer_q = 1'b0;
    logic        w_xfer_q  = 1'b0;
    logic        b_xfer_q  = 1'b0;
    logic [31:0] awaddr_q;
    logic [31:0] wdata_q;

    int bp_errs      = 0;
    int done_errs    = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    assign aw_xfer = s_axi_awvalid & s_axi_awready;
    assign w_xfer  = s_axi_wvalid & s_axi_wready;
    assign b_xfer  = s_axi_bvalid & s_axi_bready;

    rtc_init_top rtc_init_top_i (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_reset   (s_axi_reset),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .rtc_init_done (rtc_init_done)
    );

    initial begin
        forever #5 s_axi_aclk = ~s_axi_aclk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, inout int errs);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errs++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    function automatic int stall_cycles();
        return int'($urandom % 8);
    endfunction

    // ------------------------------------------------------------------------
    // slave model with random stalls on each ready and on bvalid
    // ------------------------------------------------------------------------

    always @(posedge s_axi_aclk) begin
        if (!s_axi_reset) begin
            if (aw_xfer) begin
                s_axi_awready <= 1'b0;
                aw_armed      <= 1'b0;
            end else if (s_axi_awvalid) begin
                if (!aw_armed) begin
                    aw_wait  <= stall_cycles();
                    aw_armed <= 1'b1;
                end else if (aw_wait == 0) begin
                    s_axi_awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 1;
                end
            end
            if (w_xfer) begin
                s_axi_wready <= 1'b0;
                w_armed      <= 1'b0;
            end else if (s_axi_wvalid) begin
                if (!w_armed) begin
                    w_wait  <= stall_cycles();
                    w_armed <= 1'b1;
                end else if (w_wait == 0) begin
                    s_axi_wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 1;
                end
            end
            // response only once address and data are both in
            if (aw_xfer) begin
                aw_got <= 1'b1;
            end
            if (w_xfer) begin
                w_got <= 1'b1;
            end
            if (b_xfer) begin
                s_axi_bvalid <= 1'b0;
                b_armed      <= 1'b0;
                aw_got       <= 1'b0;
                w_got        <= 1'b0;
            end else if (aw_got && w_got) begin
                if (!b_armed) begin
                    b_wait  <= stall_cycles();
                    b_armed <= 1'b1;
                end else if (b_wait == 0) begin
                    s_axi_bvalid <= 1'b1;
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // bus monitor
    // ------------------------------------------------------------------------

    always @(posedge s_axi_aclk) begin
        if (!s_axi_reset) begin
            // stalled channel keeps valid and payload
            if (awvalid_q && !aw_xfer_q) begin
                check_value("back_pressure awvalid", 32'd1, s_axi_awvalid, bp_errs);
                check_value("back_pressure awaddr", awaddr_q, s_axi_awaddr, bp_errs);
            end
            if (wvalid_q && !w_xfer_q) begin
                check_value("back_pressure wvalid", 32'd1, s_axi_wvalid, bp_errs);
                check_value("back_pressure wdata", wdata_q, s_axi_wdata, bp_errs);
            end
            if (bready_q && !b_xfer_q) begin
                check_value("back_pressure bready", 32'd1, s_axi_bready, bp_errs);
            end
            awvalid_q <= s_axi_awvalid;
            wvalid_q  <= s_axi_wvalid;
            bready_q  <= s_axi_bready;
            aw_xfer_q <= aw_xfer;
            w_xfer_q  <= w_xfer;
            b_xfer_q  <= b_xfer;
            awaddr_q  <= s_axi_awaddr;
            wdata_q   <= s_axi_wdata;

            // first cycle of each write for the settle gap
            if (s_axi_awvalid && !awvalid_q && aw_cnt < init_steps) begin
                aw_rise_cyc[aw_cnt] <= cyc;
            end
            if (aw_xfer) begin
                if (aw_cnt < init_steps) begin
                    aw_addr_seen[aw_cnt] <= s_axi_awaddr;
                end else begin
                    $display("extra write to %h after the program ended", s_axi_awaddr);
                    done_errs++;
                end
                aw_cnt <= aw_cnt + 1;
            end
            if (w_xfer) begin
                if (w_cnt < init_steps) begin
                    w_data_seen[w_cnt] <= s_axi_wdata;
                end
                w_cnt <= w_cnt + 1;
            end
            if (b_xfer) begin
                if (b_cnt < init_steps) begin
                    b_cyc[b_cnt] <= cyc;
                end
                b_cnt <= b_cnt + 1;
            end
            if (rtc_init_done && b_cnt < init_steps) begin
                $display("rtc_init_done high after only %0d write responses", b_cnt);
                done_errs++;
            end
        end
    end

    // cycle count and run limit
    always @(posedge s_axi_aclk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            $display("run stopped after %0d cycles, init program never finished", cyc);
            $display("test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin : main
        int errs;
        int n;
        int gap;

        void'($urandom(32'h27e0));
        repeat (reset_cycles) @(posedge s_axi_aclk);
        s_axi_reset <= 1'b0;

        // bus idle through the power-up delay
        errs = 0;
        repeat (powerup_delay) begin
            @(posedge s_axi_aclk);
            check_value("powerup_delay awvalid", 32'd0, s_axi_awvalid, errs);
            check_value("powerup_delay wvalid", 32'd0, s_axi_wvalid, errs);
            check_value("powerup_delay bready", 32'd0, s_axi_bready, errs);
            check_value("powerup_delay done", 32'd0, rtc_init_done, errs);
        end
        report_test("powerup_delay", errs);

        // one table entry per completed write
        for (int i = 0; i < init_steps; i++) begin
            wait (b_cnt > i);
            errs = 0;
            check_value({write_name(i), " awaddr"}, exp_addr[i], aw_addr_seen[i], errs);
            check_value({write_name(i), " wdata"}, exp_data[i], w_data_seen[i], errs);
            report_test(write_name(i), errs);
        end

        // quiet time after the rtc reset command
        // awvalid rise is sampled one edge after it goes high
        errs = 0;
        gap  = aw_rise_cyc[settle_write + 1] - b_cyc[settle_write] - 1;
        if (gap < settle_cycles) begin
            $display("only %0d cycles after the reset command, %0d needed", gap,
                     settle_cycles);
            errs++;
        end
        report_test("settle_gap", errs);

        errs = 0;
        n    = 0;
        while (rtc_init_done !== 1'b1 && n < done_wait_cycles) begin
            @(posedge s_axi_aclk);
            n++;
        end
        if (rtc_init_done !== 1'b1) begin
            $display("rtc_init_done not raised within %0d cycles", done_wait_cycles);
            errs++;
        end
        repeat (quiet_cycles) begin
            @(posedge s_axi_aclk);
            check_value("done_and_quiet awvalid", 32'd0, s_axi_awvalid, errs);
            check_value("done_and_quiet wvalid", 32'd0, s_axi_wvalid, errs);
            check_value("done_and_quiet done", 32'd1, rtc_init_done, errs);
        end
        report_test("done_and_quiet", errs + done_errs);
        report_test("back_pressure", bp_errs);

        $display("%0d tests run, %0d passed, %0d failed", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
